// File: filelist.f
+incdir+design
design/kcpu_pkg.sv
design/kcpu_memctrl.sv
design/kcpu_sequencer.sv
design/kcpu_bus_top.sv
test/kcpu_bus_chk.sv
test/kcpu_bus_tb.sv

// File: run.sh
#!/bin/sh
# compile and run the bus front end testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module kcpu_bus_tb \
    -f filelist.f -o kcpu_sim || exit 1
out=$(./obj_dir/kcpu_sim)
echo "$out"
echo "$out" | grep -q "ALL TESTS PASSED" && exit 0 || exit 1

// File: test/kcpu_bus_tb.sv
//////////////////////////////
// bus front end testbench
// memory model, directed tests, watchdog
//////////////////////////////

`include "kcpu_macros.svh"

module kcpu_bus_tb import kcpu_pkg::*; ();

    localparam int NUM_RUNS = 8;     // directed runs, each from reset
    localparam int BUDGET   = 2000;  // cycles per run

    logic        clk, rst, cen, halt, irq, firq, nmi;
    logic [ 7:0] din;
    logic [15:0] addr, pc_out, x_out;
    logic [ 7:0] acc_out;
    logic [ 7:0] mem [0:65535];
    logic [31:0] seed = 32'h125a;
    logic [15:0] pc_last;            // pc_out one sample before an addr match
    logic        cen_slow;           // cen every other cycle
    int          errors, checks;
    logic [15:0] prog, xa;
    logic [ 7:0] xbyte;

    kcpu_bus_top dut (.*);

    assign din = mem[addr];  // byte valid in the same cycle

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        forever begin
            @(posedge clk);
            #1 cen = cen_slow ? ~cen : 1'b1;
        end
    end

    function automatic logic [31:0] next_random();
        seed = seed ^ (seed << 13);
        seed = seed ^ (seed >> 17);
        seed = seed ^ (seed << 5);
        return seed;
    endfunction

    // 16-byte aligned address in the 4K region picked by top
    function automatic logic [15:0] rand_addr(input logic [3:0] top);
        logic [31:0] r;
        r = next_random();
        return {top, r[11:4], 4'h0};
    endfunction

    task automatic check_eq(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic fill_memory();
        logic [15:0] a;
        for (int i = 0; i < 65536; i++) begin
            a = i[15:0];
            mem[a] = a[15:8] ^ {a[6:0], a[7]};
        end
    endtask

    task automatic put_word(input logic [15:0] at, input logic [15:0] w);
        mem[at]         = w[15:8];  // big-endian
        mem[at + 16'd1] = w[7:0];
    endtask

    task automatic put_jmp(input logic [15:0] at, input logic [15:0] target);
        mem[at] = op_jmp;
        put_word(at + 16'd1, target);
    endtask

    task automatic reset_begin();
        @(posedge clk);
        #1 rst = 1'b1;
    endtask

    task automatic reset_end();
        repeat (3) @(posedge clk);
        #1 rst = 1'b0;
    endtask

    // one sample per cycle until addr shows target
    task automatic wait_addr(input logic [15:0] target);
        for (int n = 0; n < 200; n++) begin
            pc_last = pc_out;
            @(posedge clk);
            #1;
            if (addr === target)
                return;
        end
        errors++;
        $display("timed out after 200 cycles waiting for addr %h", target);
    endtask

    task automatic reset_vector_fetch();
        logic [15:0] v;
        v = rand_addr(4'h1);
        reset_begin();
        put_word(`KCPU_VEC_RST, v);
        put_jmp(v, v);
        reset_end();
        wait_addr(`KCPU_VEC_RST);
        @(posedge clk);
        #1;
        check_eq("addr after reset vector", addr, 16'hFFFF);  // low byte step
        wait_addr(v);
        check_eq("pc_out at first opcode fetch", pc_last, v);
    endtask

    task automatic nop_stream();
        logic [15:0] v;
        int k;
        v = rand_addr(4'h2);
        reset_begin();
        put_word(`KCPU_VEC_RST, v);
        for (k = 0; k < 6; k++)
            mem[v + k] = op_nop;
        put_jmp(v + 16'd6, v + 16'd6);
        reset_end();
        wait_addr(v);
        for (k = 1; k < 6; k++) begin
            @(posedge clk);  // cen every cycle, one step each
            #1;
            check_eq("addr in nop run", addr, v + k);
            check_eq("pc_out in nop run", pc_out, v + k + 1);  // next address out
        end
    endtask

    task automatic jump_target();
        logic [15:0] v, t;
        v = rand_addr(4'h3);
        t = rand_addr(4'h4);
        reset_begin();
        put_word(`KCPU_VEC_RST, v);
        put_jmp(v, t);
        put_jmp(t, t);
        reset_end();
        wait_addr(v);
        wait_addr(t);
        check_eq("pc_out before jump target", pc_last, t);
        wait_addr(t + 16'd4);
        wait_addr(t);  // jmp to self at the target
    endtask

    // ldx #xa, lda ,x then a jmp loop; stall adds halt and a slow cen
    task automatic indexed_load(input logic stall);
        int n;
        reset_begin();
        cen_slow = stall;
        put_word(`KCPU_VEC_RST, prog);
        mem[prog] = op_ldx;
        put_word(prog + 16'd1, xa);
        mem[prog + 16'd3] = op_lda_x;
        put_jmp(prog + 16'd4, prog + 16'd4);
        mem[xa] = xbyte;
        reset_end();
        wait_addr(prog + 16'd1);
        if (stall) begin
            halt = 1'b1;
            n = 2 + int'(next_random() % 7);
            repeat (n) @(posedge clk);
            #1;
            check_eq("addr during halt", addr, prog + 16'd1);
            halt = 1'b0;
        end
        wait_addr(xa);  // indexed read on the bus
        wait_addr(prog + 16'd8);
        wait_addr(prog + 16'd4);
        if (stall) begin
            check_eq("x_out after stall", x_out, xa);
            check_eq("acc_out after stall", acc_out, xbyte);
            check_eq("pc_out after stall", pc_last, prog + 16'd4);
        end else begin
            check_eq("x_out", x_out, xa);
            check_eq("acc_out", acc_out, xbyte);
            check_eq("pc_out at loop", pc_last, prog + 16'd4);
        end
        cen_slow = 1'b0;
    endtask

    task automatic interrupt_case(input logic n_in, input logic f_in, input logic i_in,
                                  input logic [15:0] loc);
        logic [15:0] v, h, seen;
        v = rand_addr(4'h5);
        reset_begin();
        put_word(`KCPU_VEC_RST, v);
        put_jmp(v, v);
        put_word(`KCPU_VEC_IRQ, rand_addr(4'hA));
        put_word(`KCPU_VEC_FIRQ, rand_addr(4'hB));
        put_word(`KCPU_VEC_NMI, rand_addr(4'hC));
        h = {mem[loc], mem[loc + 16'd1]};  // expected handler
        put_jmp(h, h);
        reset_end();
        wait_addr(v);
        nmi  = n_in;
        firq = f_in;
        irq  = i_in;
        seen = 16'h0000;
        for (int k = 0; k < 200 && seen == 16'h0000; k++) begin
            @(posedge clk);
            #1;
            if (addr == `KCPU_VEC_NMI || addr == `KCPU_VEC_FIRQ || addr == `KCPU_VEC_IRQ)
                seen = addr;
        end
        nmi  = 1'b0;  // held until the vector showed up
        firq = 1'b0;
        irq  = 1'b0;
        if (seen == 16'h0000) begin
            errors++;
            $display("no vector location appeared on addr within 200 cycles");
        end else begin
            check_eq("first vector location", seen, loc);
        end
        wait_addr(h);
        check_eq("pc_out before handler", pc_last, h);
    endtask

    initial begin
        logic [31:0] r;
        rst      = 1'b1;
        cen      = 1'b1;
        halt     = 1'b0;
        irq      = 1'b0;
        firq     = 1'b0;
        nmi      = 1'b0;
        cen_slow = 1'b0;
        errors   = 0;
        checks   = 0;
        fill_memory();
        prog  = rand_addr(4'h6);
        r     = next_random();
        xa    = {3'b100, r[12:0]};
        xbyte = r[20:13];
        reset_vector_fetch();
        nop_stream();
        jump_target();
        indexed_load(1'b0);
        interrupt_case(1'b1, 1'b1, 1'b1, `KCPU_VEC_NMI);
        interrupt_case(1'b0, 1'b1, 1'b0, `KCPU_VEC_FIRQ);
        interrupt_case(1'b0, 1'b0, 1'b1, `KCPU_VEC_IRQ);
        indexed_load(1'b1);
        $display("errors: %0d of %0d checks", errors, checks);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        #(NUM_RUNS * BUDGET * 10);
        $display("timeout, tests still running after %0d cycles, errors: %0d",
                 NUM_RUNS * BUDGET, errors);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// File: test/kcpu_bus_chk.sv
//////////////////////////////
// memory controller assertions
//////////////////////////////

`include "kcpu_macros.svh"

module kcpu_bus_chk (
    input logic        clk,
    input logic        rst,
    input logic        cen,
    input logic        halt,
    input logic        busy,
    input logic [15:0] addr
);

    logic step;

    assign step = cen && !halt;  // one bus access

    // second vector byte takes one step only
    busy_single: assert property (@(posedge clk) disable iff (rst)
        step && busy |=> !busy)
        else $error("busy high for two steps");

    halt_hold: assert property (@(posedge clk) disable iff (rst)
        halt |=> $stable(addr))
        else $error("addr moved while halted");

    // low byte address follows one of the vector locations
    vec_next: assert property (@(posedge clk) disable iff (rst)
        step && busy |=> addr inside {`KCPU_VEC_IRQ + 16'd1, `KCPU_VEC_FIRQ + 16'd1,
                                      `KCPU_VEC_NMI + 16'd1, `KCPU_VEC_RST + 16'd1})
        else $error("vector low byte address wrong");

endmodule

bind kcpu_memctrl kcpu_bus_chk u_chk (.*);

// File: design/kcpu_bus_top.sv
//////////////////////////////
// bus front end top level
// sequencer plus memory controller
//////////////////////////////

module kcpu_bus_top import kcpu_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,
    input  logic        halt,
    input  logic        irq,
    input  logic        firq,
    input  logic        nmi,
    // memory port
    input  logic [ 7:0] din,
    output logic [15:0] addr,
    // register views
    output logic [15:0] pc_out,
    output logic [15:0] x_out,
    output logic [ 7:0] acc_out
);

    logic [15:0] data;   // assembled read result
    logic        busy;
    logic        idx_en;
    vec_e        vector;

    // pc and x feed the address mux and the ports alike
    kcpu_sequencer u_seq (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .halt     (halt),
        .irq      (irq),
        .firq     (firq),
        .nmi      (nmi),
        .data     (data),
        .busy     (busy),
        .pc       (pc_out),
        .idx_addr (x_out),
        .idx_en   (idx_en),
        .vector   (vector),
        .acc      (acc_out)
    );

    kcpu_memctrl u_mem (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .halt     (halt),
        .pc       (pc_out),
        .idx_addr (x_out),
        .idx_en   (idx_en),
        .vector   (vector),
        .din      (din),
        .data     (data),
        .busy     (busy),
        .addr     (addr)
    );

endmodule

// File: design/kcpu_sequencer.sv
//////////////////////////////
// instruction sequencer
// reset and interrupt vectors, decode, pc, x, acc
//////////////////////////////

module kcpu_sequencer import kcpu_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,
    input  logic        halt,
    // interrupt requests, level
    input  logic        irq,
    input  logic        firq,
    input  logic        nmi,
    // from the memory controller
    input  logic [15:0] data,
    input  logic        busy,
    // address sources
    output logic [15:0] pc,       // fetch pointer
    output logic [15:0] idx_addr, // x register
    output logic        idx_en,
    output vec_e        vector,
    output logic [ 7:0] acc
);

    // fetch runs two bytes ahead of decode:
    // in sequential flow data[7:0] holds the byte at pc-2

    logic       step;    // access step with no vector byte pending
    seq_state_e state;
    logic       skip;    // first of two bubble steps
    opcode_e    op;      // instruction in progress
    opcode_e    op_in;   // byte in data seen as an opcode
    logic [7:0] hi;      // operand high byte
    vec_e       req_vec; // highest pending request

    assign step  = cen && !halt && !busy;
    assign op_in = opcode_e'(data[7:0]);

    // reset request is the reset state itself, so nmi is first here
    always_comb begin
        if (nmi)
            req_vec = vec_nmi;
        else if (firq)
            req_vec = vec_firq;
        else if (irq)
            req_vec = vec_irq;
        else
            req_vec = vec_none;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= st_vector;
            vector   <= vec_rst;   // first step goes to FFFE
            skip     <= 1'b0;
            op       <= op_nop;
            hi       <= 8'h00;
            pc       <= 16'h0000;
            idx_addr <= 16'h0000;
            idx_en   <= 1'b0;
            acc      <= 8'h00;
        end else if (step) begin
            case (state)
                st_vector: begin
                    if (vector != vec_none) begin
                        vector <= vec_none; // location is on the bus now
                        skip   <= 1'b1;
                    end else if (skip) begin
                        skip <= 1'b0;       // low byte lands this step
                    end else begin
                        pc    <= data;      // whole vector word
                        op    <= op_nop;
                        skip  <= 1'b1;
                        state <= st_exec;   // flush two stale fetches
                    end
                end
                st_opcode: begin
                    // instruction boundary, requests go first
                    if (req_vec != vec_none) begin
                        vector <= req_vec;
                        state  <= st_vector;
                    end else begin
                        case (op_in)
                            op_jmp, op_ldx: begin
                                op    <= op_in;
                                pc    <= pc + 16'd1;
                                state <= st_op_hi;
                            end
                            op_lda_x: begin
                                op     <= op_in;
                                idx_en <= 1'b1;        // x on the bus next step
                                pc     <= pc - 16'd2;  // refetch the byte after
                                skip   <= 1'b1;
                                state  <= st_exec;
                            end
                            default: begin
                                op <= op_nop;          // unknown bytes too
                                pc <= pc + 16'd1;
                            end
                        endcase
                    end
                end
                st_op_hi: begin
                    hi    <= data[7:0];
                    pc    <= pc + 16'd1;
                    state <= st_op_lo;
                end
                st_op_lo: begin
                    case (op)
                        op_jmp: begin
                            pc    <= {hi, data[7:0]};
                            skip  <= 1'b1;
                            state <= st_exec;
                        end
                        op_ldx: begin
                            idx_addr <= {hi, data[7:0]};
                            pc       <= pc + 16'd1;
                            state    <= st_opcode;
                        end
                        default: begin
                            acc   <= data[7:0];  // indexed byte
                            pc    <= pc + 16'd1;
                            state <= st_opcode;
                        end
                    endcase
                end
                st_exec: begin
                    idx_en <= 1'b0;
                    pc     <= pc + 16'd1;  // keep the prefetch going
                    if (skip)
                        skip <= 1'b0;
                    else if (op == op_lda_x)
                        state <= st_op_lo;  // indexed byte arrives next
                    else
                        state <= st_opcode;
                end
                default: state <= st_opcode;
            endcase
        end
    end

endmodule

// File: design/kcpu_memctrl.sv
//////////////////////////////
// memory controller
// address mux, byte assembly, vector fetch
//////////////////////////////

`include "kcpu_macros.svh"

module kcpu_memctrl import kcpu_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,
    input  logic        halt,     // freeze the bus, slow memory
    // address sources
    input  logic [15:0] pc,
    input  logic [15:0] idx_addr,
    input  logic        idx_en,
    input  vec_e        vector,
    // result back to the sequencer
    output logic [15:0] data,     // 8-bit in [7:0], vectors big-endian
    output logic        busy,     // second vector byte pending
    // memory port
    input  logic [ 7:0] din,
    output logic [15:0] addr
);

    logic        step;      // one bus access
    logic [15:0] vec_addr;  // location for the requested vector
    logic [15:0] next_addr;

    assign step = cen && !halt;

    always_comb begin
        case (vector)
            vec_irq:  vec_addr = `KCPU_VEC_IRQ;
            vec_firq: vec_addr = `KCPU_VEC_FIRQ;
            vec_nmi:  vec_addr = `KCPU_VEC_NMI;
            vec_rst:  vec_addr = `KCPU_VEC_RST;
            default:  vec_addr = 16'h0000; // not selected below
        endcase
    end

    // vector beats index, index beats pc
    always_comb begin
        if (vector != vec_none)
            next_addr = vec_addr;
        else if (idx_en)
            next_addr = idx_addr;
        else
            next_addr = pc;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            addr <= 16'h0000;
            busy <= 1'b0;
        end else if (step) begin
            if (busy) begin
                addr <= addr + 16'd1;  // low byte of the vector word
                busy <= 1'b0;
            end else begin
                addr <= next_addr;
                busy <= (vector != vec_none);
            end
        end
    end

    // byte assembly, high half only in the busy step
    always_ff @(posedge clk) begin
        if (step) begin
            if (busy)
                data[15:8] <= din;
            else
                data[7:0]  <= din;
        end
    end

endmodule

// File: design/kcpu_pkg.sv
//////////////////////////////
// shared enums for the bus front end
// vector codes, sequencer states, opcodes
//////////////////////////////

`include "kcpu_macros.svh"

package kcpu_pkg;

    // interrupt vector request codes, 0 leaves the bus alone
    typedef enum logic [2:0] {
        vec_none = 3'd0,
        vec_irq  = 3'd1,
        vec_firq = 3'd2,
        vec_nmi  = 3'd3,
        vec_rst  = 3'd4
    } vec_e;

    // what the sequencer expects in data[7:0] on a step
    typedef enum logic [2:0] {
        st_vector, // vector issue, wait and pc load
        st_opcode, // opcode byte
        st_op_hi,  // operand high byte
        st_op_lo,  // operand low byte or indexed byte
        st_exec    // pipeline bubbles after a redirect
    } seq_state_e;

    // opcode bytes, values shared with the testbench
    typedef enum logic [7:0] {
        op_nop   = `KCPU_OP_NOP,
        op_jmp   = `KCPU_OP_JMP,
        op_ldx   = `KCPU_OP_LDX,
        op_lda_x = `KCPU_OP_LDA_X
    } opcode_e;

endpackage

// File: design/kcpu_macros.svh
//////////////////////////////
// vector locations and opcode bytes
//////////////////////////////

`ifndef KCPU_MACROS_SVH
`define KCPU_MACROS_SVH

// interrupt vector locations, each holds a big-endian word
`define KCPU_VEC_IRQ  16'hFFF8
`define KCPU_VEC_FIRQ 16'hFFF6
`define KCPU_VEC_NMI  16'hFFFC
`define KCPU_VEC_RST  16'hFFFE

// opcode byte values
`define KCPU_OP_NOP   8'h12 // no operation
`define KCPU_OP_JMP   8'h7E // jmp extended, 16-bit target
`define KCPU_OP_LDX   8'h8E // ldx immediate, 16-bit operand
`define KCPU_OP_LDA_X 8'hA6 // lda indexed, byte at x

// a vector word takes two bytes
`define KCPU_VEC_BYTES 2

`endif
